//--- trap_pkg.sv
// Machine-mode trap subsystem shared definitions
// Cause codes, privilege values, load/store width codes and bus offsets

`default_nettype none

package trap_pkg;

  // ==================================================
  // Fixed-width types
  // ==================================================

  // Exception cause code as stored in mcause
  typedef logic [4:0] cause_t;
  // Privilege mode encoding
  typedef logic [1:0] priv_t;
  // Instructions are always 32 bits, also on RV64
  typedef logic [31:0] inst_t;
  // Load/store width field of the instruction
  typedef logic [2:0] funct3_t;
  // Byte offset of a trap register on the bus
  typedef logic [4:0] csr_addr_t;

  // ==================================================
  // Exception cause codes
  // ==================================================

  localparam cause_t CAUSE_INST_MISALIGNED  = 5'd0;
  localparam cause_t CAUSE_ILLEGAL_INST     = 5'd2;
  localparam cause_t CAUSE_BREAKPOINT       = 5'd3;
  localparam cause_t CAUSE_LOAD_MISALIGNED  = 5'd4;
  localparam cause_t CAUSE_STORE_MISALIGNED = 5'd6;
  localparam cause_t CAUSE_ECALL_U          = 5'd8;
  localparam cause_t CAUSE_ECALL_S          = 5'd9;
  localparam cause_t CAUSE_ECALL_M          = 5'd11;
  localparam cause_t CAUSE_LOAD_PAGE_FAULT  = 5'd13;
  localparam cause_t CAUSE_STORE_PAGE_FAULT = 5'd15;

  // Privilege levels, value 2 is reserved
  localparam priv_t PRIV_U = 2'd0;
  localparam priv_t PRIV_S = 2'd1;
  localparam priv_t PRIV_M = 2'd3;

  // Load/store width codes, stores use the signed subset
  localparam funct3_t F3_B  = 3'b000;
  localparam funct3_t F3_H  = 3'b001;
  localparam funct3_t F3_W  = 3'b010;
  localparam funct3_t F3_D  = 3'b011;
  localparam funct3_t F3_BU = 3'b100;
  localparam funct3_t F3_HU = 3'b101;
  localparam funct3_t F3_WU = 3'b110;

  // ==================================================
  // Trap register map on the bus
  // ==================================================

  localparam csr_addr_t OFS_MTVEC  = 5'h00;
  localparam csr_addr_t OFS_MEPC   = 5'h04;
  localparam csr_addr_t OFS_MCAUSE = 5'h08;
  localparam csr_addr_t OFS_MTVAL  = 5'h0C;
  localparam csr_addr_t OFS_PRIV   = 5'h10;

endpackage

`default_nettype wire

//--- exception_unit.sv
// Exception detector
// Collects fault flags of the fetch, decode and memory stages and
// selects one exception by fixed priority, with cause, pc and trap value

`timescale 1ns/10ps
`default_nettype none

module exception_unit #(
  parameter int unsigned xlen            = 32,
  parameter bit          c_ext           = 1'b1,
  parameter bit          misaligned_trap = 1'b1
) (
  // Current privilege, selects the ecall cause
  input  wire trap_pkg::priv_t   current_priv,
  // Fetch stage
  input  wire                    if_valid,
  input  wire [xlen-1:0]         if_pc,
  // Decode stage
  input  wire                    id_valid,
  input  wire [xlen-1:0]         id_pc,
  input  wire trap_pkg::inst_t   id_instruction,
  input  wire                    id_illegal_inst,
  input  wire                    id_ecall,
  input  wire                    id_ebreak,
  // Memory stage
  input  wire                    mem_valid,
  input  wire [xlen-1:0]         mem_pc,
  input  wire trap_pkg::inst_t   mem_instruction,
  input  wire [xlen-1:0]         mem_addr,
  input  wire                    mem_read,
  input  wire                    mem_write,
  input  wire trap_pkg::funct3_t mem_funct3,
  input  wire                    mem_page_fault,
  input  wire [xlen-1:0]         mem_fault_vaddr,
  // Selected exception
  output logic                   exception,
  output trap_pkg::cause_t       exception_code,
  output logic [xlen-1:0]        exception_pc,
  output logic [xlen-1:0]        exception_val
);

  import trap_pkg::*;

  // ==================================================
  // Per-stage fault conditions
  // ==================================================

  logic   if_misaligned;
  logic   id_break_exc;
  logic   id_call_exc;
  logic   id_illegal_exc;
  logic   data_misaligned;
  logic   load_page_fault;
  logic   store_page_fault;
  logic   load_misaligned;
  logic   store_misaligned;
  cause_t ecall_cause;

  // Fetch alignment, 2-byte with compressed, else 4-byte
  assign if_misaligned = if_valid && (c_ext ? if_pc[0] : (if_pc[1:0] != 2'b00));

  // Decode stage flags
  assign id_break_exc   = id_valid && id_ebreak;
  assign id_call_exc    = id_valid && id_ecall;
  assign id_illegal_exc = id_valid && id_illegal_inst;

  // Ecall cause follows the mode the call was made from
  always_comb begin
    case (current_priv)
      PRIV_U:  ecall_cause = CAUSE_ECALL_U;
      PRIV_S:  ecall_cause = CAUSE_ECALL_S;
      default: ecall_cause = CAUSE_ECALL_M;
    endcase
  end

  // Natural alignment per access width
  always_comb begin
    case (mem_funct3)
      F3_B, F3_BU: data_misaligned = 1'b0;
      F3_H, F3_HU: data_misaligned = mem_addr[0];
      F3_W, F3_WU: data_misaligned = (mem_addr[1:0] != 2'b00);
      F3_D:        data_misaligned = (mem_addr[2:0] != 3'b000);
      default:     data_misaligned = 1'b0;
    endcase
  end

  // A write with the read flag set counts as a store (AMO style)
  assign load_page_fault  = mem_valid && mem_page_fault && mem_read && !mem_write;
  assign store_page_fault = mem_valid && mem_page_fault && mem_write;

  // Misalignment traps only when the memory system cannot split accesses
  assign load_misaligned  = misaligned_trap && mem_valid && mem_read && !mem_write &&
                            data_misaligned;
  assign store_misaligned = misaligned_trap && mem_valid && mem_write && data_misaligned;

  // ==================================================
  // Priority selection
  // ==================================================

  always_comb begin
    // Nothing pending
    exception      = 1'b0;
    exception_code = CAUSE_INST_MISALIGNED;
    exception_pc   = '0;
    exception_val  = '0;
    if (if_misaligned) begin
      exception      = 1'b1;
      exception_code = CAUSE_INST_MISALIGNED;
      exception_pc   = if_pc;
      exception_val  = if_pc;
    end else if (id_break_exc) begin
      exception      = 1'b1;
      exception_code = CAUSE_BREAKPOINT;
      exception_pc   = id_pc;
      exception_val  = id_pc;
    end else if (id_call_exc) begin
      // Trap value stays zero for ecall
      exception      = 1'b1;
      exception_code = ecall_cause;
      exception_pc   = id_pc;
    end else if (id_illegal_exc) begin
      exception      = 1'b1;
      exception_code = CAUSE_ILLEGAL_INST;
      exception_pc   = id_pc;
      exception_val  = xlen'(id_instruction);
    end else if (load_page_fault) begin
      exception      = 1'b1;
      exception_code = CAUSE_LOAD_PAGE_FAULT;
      exception_pc   = mem_pc;
      exception_val  = mem_fault_vaddr;
    end else if (store_page_fault) begin
      exception      = 1'b1;
      exception_code = CAUSE_STORE_PAGE_FAULT;
      exception_pc   = mem_pc;
      exception_val  = mem_fault_vaddr;
    end else if (load_misaligned) begin
      exception      = 1'b1;
      exception_code = CAUSE_LOAD_MISALIGNED;
      exception_pc   = mem_pc;
      exception_val  = mem_addr;
    end else if (store_misaligned) begin
      exception      = 1'b1;
      exception_code = CAUSE_STORE_MISALIGNED;
      exception_pc   = mem_pc;
      exception_val  = mem_addr;
    end
  end

endmodule

`default_nettype wire

//--- trap_csr_file.sv
// Machine trap register block
// Holds mtvec, mepc, mcause, mtval and the privilege mode, takes traps,
// performs mret and decodes register accesses from the bus slave

`timescale 1ns/10ps
`default_nettype none

module trap_csr_file #(
  parameter int unsigned xlen  = 32,
  parameter bit          c_ext = 1'b1
) (
  input  wire                      clk,
  input  wire                      rst,
  // Trap entry from the detector
  input  wire                      exception,
  input  wire trap_pkg::cause_t    exception_code,
  input  wire [xlen-1:0]           exception_pc,
  input  wire [xlen-1:0]           exception_val,
  // Return from trap, one-cycle pulse
  input  wire                      mret,
  // Register access from the bus
  input  wire                      csr_sel,
  input  wire                      csr_write,
  input  wire trap_pkg::csr_addr_t csr_addr,
  input  wire [xlen-1:0]           csr_wdata,
  output logic [xlen-1:0]          csr_rdata,
  output logic                     csr_err,
  // Status towards the core
  output trap_pkg::priv_t          current_priv,
  output logic [xlen-1:0]          trap_target,
  output logic [xlen-1:0]          ret_pc
);

  import trap_pkg::*;

  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mepc;
  cause_t          mcause;
  logic [xlen-1:0] mtval;
  priv_t           priv;
  priv_t           mpp;
  priv_t           mpp_wdata;
  logic            bus_wr;

  assign bus_wr = csr_sel && csr_write;

  // Reserved mode value falls back to U
  assign mpp_wdata = (csr_wdata[3:2] == 2'b10) ? PRIV_U : priv_t'(csr_wdata[3:2]);

  // ==================================================
  // Register update
  // ==================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      mtvec  <= '0;
      mepc   <= '0;
      mcause <= '0;
      mtval  <= '0;
      priv   <= PRIV_M;
      mpp    <= PRIV_U;
    end else begin
      // Bus writes, mcause and mtval are read-only here
      if (bus_wr) begin
        case (csr_addr)
          OFS_MTVEC: mtvec <= {csr_wdata[xlen-1:2], 2'b00};
          OFS_MEPC: begin
            if (c_ext) begin
              mepc <= {csr_wdata[xlen-1:1], 1'b0};
            end else begin
              mepc <= {csr_wdata[xlen-1:2], 2'b00};
            end
          end
          OFS_PRIV:  mpp <= mpp_wdata;
          default: ;
        endcase
      end
      // Trap entry overrides a bus write in the same cycle
      if (exception) begin
        mepc   <= exception_pc;
        mcause <= exception_code;
        mtval  <= exception_val;
        mpp    <= priv;
        priv   <= PRIV_M;
      end else if (mret) begin
        priv <= mpp;
        mpp  <= PRIV_U;
      end
    end
  end

  // ==================================================
  // Read decode and access check
  // ==================================================

  always_comb begin
    case (csr_addr)
      OFS_MTVEC:  csr_rdata = mtvec;
      OFS_MEPC:   csr_rdata = mepc;
      OFS_MCAUSE: csr_rdata = xlen'(mcause);
      OFS_MTVAL:  csr_rdata = mtval;
      // priv in 1:0, mpp in 3:2
      OFS_PRIV:   csr_rdata = xlen'({mpp, priv});
      default:    csr_rdata = '0;
    endcase
  end

  always_comb begin
    case (csr_addr)
      OFS_MTVEC, OFS_MEPC, OFS_PRIV: csr_err = 1'b0;
      OFS_MCAUSE, OFS_MTVAL:         csr_err = csr_write;
      default:                       csr_err = 1'b1;
    endcase
  end

  assign current_priv = priv;
  assign trap_target  = mtvec;
  assign ret_pc       = mepc;

endmodule

`default_nettype wire

//--- csr_apb_slave.sv
// APB completer for the trap registers
// Adds one wait state per transfer and registers read data and error

`timescale 1ns/10ps
`default_nettype none

module csr_apb_slave #(
  parameter int unsigned xlen = 32
) (
  input  wire                      clk,
  input  wire                      rst,
  // APB side
  input  wire                      psel,
  input  wire                      penable,
  input  wire                      pwrite,
  input  wire trap_pkg::csr_addr_t paddr,
  input  wire [xlen-1:0]           pwdata,
  output logic                     pready,
  output logic [xlen-1:0]          prdata,
  output logic                     pslverr,
  // Register block side
  input  wire [xlen-1:0]           csr_rdata,
  input  wire                      csr_err,
  output logic                     csr_sel,
  output logic                     csr_write,
  output trap_pkg::csr_addr_t      csr_addr,
  output logic [xlen-1:0]          csr_wdata
);

  // Setup seen, then first access cycle, then completion
  typedef enum logic [1:0] {
    s_idle,
    s_wait,
    s_done
  } apb_state_t;

  apb_state_t state;

  // ==================================================
  // Transfer sequencing
  // ==================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= s_idle;
      pslverr <= 1'b0;
    end else begin
      case (state)
        s_idle: begin
          if (psel && !penable) begin
            state <= s_wait;
          end
        end
        s_wait: begin
          // Abandoned transfer returns to idle
          if (psel && penable) begin
            state   <= s_done;
            pslverr <= csr_err;
          end else begin
            state <= s_idle;
          end
        end
        default: begin
          state   <= s_idle;
          pslverr <= 1'b0;
        end
      endcase
    end
  end

  // Read data sampled during the wait state
  always_ff @(posedge clk) begin
    if (state == s_wait) begin
      prdata <= csr_rdata;
    end
  end

  assign pready = (state == s_done);

  // Access is committed on the completing cycle only
  assign csr_sel   = (state == s_done);
  assign csr_write = psel && pwrite;
  assign csr_addr  = paddr;
  assign csr_wdata = pwdata;

endmodule

`default_nettype wire

//--- trap_subsystem.sv
// Machine-mode trap subsystem top level
// Connects the exception detector, trap registers and APB slave

`timescale 1ns/10ps
`default_nettype none

module trap_subsystem #(
  parameter int unsigned xlen            = 32,
  parameter bit          c_ext           = 1'b1,
  parameter bit          misaligned_trap = 1'b1
) (
  input  wire                      clk,
  input  wire                      rst,
  // Fetch stage
  input  wire                      if_valid,
  input  wire [xlen-1:0]           if_pc,
  // Decode stage
  input  wire                      id_valid,
  input  wire [xlen-1:0]           id_pc,
  input  wire trap_pkg::inst_t     id_instruction,
  input  wire                      id_illegal_inst,
  input  wire                      id_ecall,
  input  wire                      id_ebreak,
  // Memory stage
  input  wire                      mem_valid,
  input  wire [xlen-1:0]           mem_pc,
  input  wire trap_pkg::inst_t     mem_instruction,
  input  wire [xlen-1:0]           mem_addr,
  input  wire                      mem_read,
  input  wire                      mem_write,
  input  wire trap_pkg::funct3_t   mem_funct3,
  input  wire                      mem_page_fault,
  input  wire [xlen-1:0]           mem_fault_vaddr,
  // Return from trap
  input  wire                      mret,
  // APB
  input  wire                      psel,
  input  wire                      penable,
  input  wire                      pwrite,
  input  wire trap_pkg::csr_addr_t paddr,
  input  wire [xlen-1:0]           pwdata,
  output wire                      pready,
  output wire [xlen-1:0]           prdata,
  output wire                      pslverr,
  // Trap status
  output wire                      trap,
  output trap_pkg::cause_t         trap_cause,
  output wire [xlen-1:0]           trap_val,
  output wire [xlen-1:0]           trap_target,
  output wire [xlen-1:0]           ret_pc,
  output trap_pkg::priv_t          priv
);

  import trap_pkg::*;

  wire [xlen-1:0] trap_pc;
  wire            csr_sel;
  wire            csr_write;
  csr_addr_t      csr_addr;
  wire [xlen-1:0] csr_wdata;
  wire [xlen-1:0] csr_rdata;
  wire            csr_err;

  exception_unit #(
    .xlen            (xlen),
    .c_ext           (c_ext),
    .misaligned_trap (misaligned_trap)
  ) u_exception_unit (
    .current_priv    (priv),
    .if_valid        (if_valid),
    .if_pc           (if_pc),
    .id_valid        (id_valid),
    .id_pc           (id_pc),
    .id_instruction  (id_instruction),
    .id_illegal_inst (id_illegal_inst),
    .id_ecall        (id_ecall),
    .id_ebreak       (id_ebreak),
    .mem_valid       (mem_valid),
    .mem_pc          (mem_pc),
    .mem_instruction (mem_instruction),
    .mem_addr        (mem_addr),
    .mem_read        (mem_read),
    .mem_write       (mem_write),
    .mem_funct3      (mem_funct3),
    .mem_page_fault  (mem_page_fault),
    .mem_fault_vaddr (mem_fault_vaddr),
    .exception       (trap),
    .exception_code  (trap_cause),
    .exception_pc    (trap_pc),
    .exception_val   (trap_val)
  );

  trap_csr_file #(
    .xlen  (xlen),
    .c_ext (c_ext)
  ) u_trap_csr_file (
    .clk            (clk),
    .rst            (rst),
    .exception      (trap),
    .exception_code (trap_cause),
    .exception_pc   (trap_pc),
    .exception_val  (trap_val),
    .mret           (mret),
    .csr_sel        (csr_sel),
    .csr_write      (csr_write),
    .csr_addr       (csr_addr),
    .csr_wdata      (csr_wdata),
    .csr_rdata      (csr_rdata),
    .csr_err        (csr_err),
    .current_priv   (priv),
    .trap_target    (trap_target),
    .ret_pc         (ret_pc)
  );

  csr_apb_slave #(
    .xlen (xlen)
  ) u_csr_apb_slave (
    .clk       (clk),
    .rst       (rst),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .pready    (pready),
    .prdata    (prdata),
    .pslverr   (pslverr),
    .csr_rdata (csr_rdata),
    .csr_err   (csr_err),
    .csr_sel   (csr_sel),
    .csr_write (csr_write),
    .csr_addr  (csr_addr),
    .csr_wdata (csr_wdata)
  );

endmodule

`default_nettype wire

//--- tb_trap_vectors.svh
// Pipeline scenario table for the trap subsystem testbench
// One row per scenario with stage inputs, pre-set privilege and expected trap

`ifndef TB_TRAP_VECTORS_SVH
`define TB_TRAP_VECTORS_SVH

localparam int num_rows = 24;

row_t rows [num_rows];

// Columns are priv, flags, funct3, pc, inst, addr, rnd, exp_trap, exp_cause, exp_val
// Flags are if_v _ id_v ebreak ecall illegal _ mem_v read write page_fault
// The fault vaddr driven is always addr + 0x1000
task automatic load_rows();
  // Single fetch faults, c_ext off
  rows[0]  = '{PRIV_M, 9'b1_0000_0000, F3_W, 'h1002, 'h13, 'h0, 1'b0, 1'b1, 5'd0, 'h1002};
  rows[1]  = '{PRIV_M, 9'b1_0000_0000, F3_W, 'h1001, 'h13, 'h0, 1'b0, 1'b1, 5'd0, 'h1001};
  rows[2]  = '{PRIV_M, 9'b1_0000_0000, F3_W, 'h1004, 'h13, 'h0, 1'b0, 1'b0, 5'd0, 'h0};
  // Decode stage
  rows[3]  = '{PRIV_M, 9'b0_1100_0000, F3_W, 'h2000, 'h13, 'h0, 1'b0, 1'b1, 5'd3, 'h2000};
  rows[4]  = '{PRIV_M, 9'b0_1001_0000, F3_W, 'h2004, 'h7fff3, 'h0, 1'b0, 1'b1, 5'd2, 'h7fff3};
  rows[5]  = '{PRIV_M, 9'b0_1101_0000, F3_W, 'h2008, 'h7fff3, 'h0, 1'b0, 1'b1, 5'd3, 'h2008};
  // Ecall cause per privilege
  rows[6]  = '{PRIV_U, 9'b0_1010_0000, F3_W, 'h3000, 'h73, 'h0, 1'b0, 1'b1, 5'd8, 'h0};
  rows[7]  = '{PRIV_S, 9'b0_1010_0000, F3_W, 'h3004, 'h73, 'h0, 1'b0, 1'b1, 5'd9, 'h0};
  rows[8]  = '{PRIV_M, 9'b0_1010_0000, F3_W, 'h3008, 'h73, 'h0, 1'b0, 1'b1, 5'd11, 'h0};
  rows[9]  = '{PRIV_M, 9'b0_1011_0000, F3_W, 'h300c, 'h73, 'h0, 1'b0, 1'b1, 5'd11, 'h0};
  // Memory stage page faults and misalignment
  rows[10] = '{PRIV_M, 9'b0_0000_1101, F3_W, 'h4000, 'h3, 'h4000, 1'b0, 1'b1, 5'd13, 'h5000};
  rows[11] = '{PRIV_M, 9'b0_0000_1011, F3_W, 'h4004, 'h23, 'h4100, 1'b0, 1'b1, 5'd15, 'h5100};
  rows[12] = '{PRIV_M, 9'b0_0000_1111, F3_W, 'h4008, 'h2f, 'h4200, 1'b0, 1'b1, 5'd15, 'h5200};
  rows[13] = '{PRIV_M, 9'b0_0000_1101, F3_W, 'h400c, 'h3, 'h4003, 1'b0, 1'b1, 5'd13, 'h5003};
  rows[14] = '{PRIV_M, 9'b0_0000_1100, F3_H, 'h4010, 'h3, 'h4001, 1'b0, 1'b1, 5'd4, 'h4001};
  rows[15] = '{PRIV_M, 9'b0_0000_1010, F3_W, 'h4014, 'h23, 'h4102, 1'b0, 1'b1, 5'd6, 'h4102};
  // Valid stages without a fault, then nothing valid
  rows[16] = '{PRIV_M, 9'b1_1000_1100, F3_W, 'h6000, 'h3, 'h4004, 1'b0, 1'b0, 5'd0, 'h0};
  rows[17] = '{PRIV_U, 9'b0_0000_0000, F3_W, 'h6004, 'h13, 'h0, 1'b0, 1'b0, 5'd0, 'h0};
  // Mixed stages
  rows[18] = '{PRIV_M, 9'b1_1001_1100, F3_D, 'h6002, 'h3, 'h4004, 1'b0, 1'b1, 5'd0, 'h6002};
  rows[19] = '{PRIV_M, 9'b0_1001_1101, F3_W, 'h6008, 'h1234, 'h4000, 1'b0, 1'b1, 5'd2, 'h1234};
  // Random pc and address, expectation worked out at run time
  rows[20] = '{PRIV_M, 9'b1_0000_0000, F3_W, 'h0, 'h13, 'h0, 1'b1, 1'b0, 5'd0, 'h0};
  rows[21] = '{PRIV_U, 9'b0_0000_1100, F3_H, 'h0, 'h3, 'h0, 1'b1, 1'b0, 5'd0, 'h0};
  rows[22] = '{PRIV_S, 9'b0_0000_1100, F3_WU, 'h0, 'h3, 'h0, 1'b1, 1'b0, 5'd0, 'h0};
  rows[23] = '{PRIV_M, 9'b0_0000_1010, F3_D, 'h0, 'h23, 'h0, 1'b1, 1'b0, 5'd0, 'h0};
endtask

`endif

//--- tb_trap_subsystem.sv
// Testbench for the machine-mode trap subsystem
// Applies a table of pipeline scenarios, checks the trap outputs and
// reads the trap registers back over APB

`timescale 1ns/10ps
`default_nettype none

module tb_trap_subsystem;

  import trap_pkg::*;

  // One scenario of the table
  typedef struct packed {
    priv_t       priv;
    logic [8:0]  flags;
    funct3_t     funct3;
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] addr;
    logic        rnd;
    logic        exp_trap;
    cause_t      exp_cause;
    logic [31:0] exp_val;
  } row_t;

  `include "tb_trap_vectors.svh"

  localparam int cycle_limit = 40 * num_rows + 200;

  logic clk;
  logic rst;
  logic if_valid;
  logic [31:0] if_pc;
  logic id_valid;
  logic [31:0] id_pc;
  inst_t id_instruction;
  logic id_illegal_inst;
  logic id_ecall;
  logic id_ebreak;
  logic mem_valid;
  logic [31:0] mem_pc;
  inst_t mem_instruction;
  logic [31:0] mem_addr;
  logic mem_read;
  logic mem_write;
  funct3_t mem_funct3;
  logic mem_page_fault;
  logic [31:0] mem_fault_vaddr;
  logic mret;
  logic psel;
  logic penable;
  logic pwrite;
  csr_addr_t paddr;
  logic [31:0] pwdata;
  wire pready;
  wire [31:0] prdata;
  wire pslverr;
  wire trap;
  cause_t trap_cause;
  wire [31:0] trap_val;
  wire [31:0] trap_target;
  wire [31:0] ret_pc;
  priv_t priv;

  int error_count = 0;
  int check_count = 0;
  int cycle_count = 0;
  logic [31:0] lcg_state = 32'd81;
  // Model of the trap registers updated only by expected traps
  logic [31:0] exp_mepc = '0;
  logic [31:0] exp_mcause = '0;
  logic [31:0] exp_mtval = '0;

  trap_subsystem #(
    .xlen            (32),
    .c_ext           (1'b0),
    .misaligned_trap (1'b1)
  ) UUT (
    .clk (clk), .rst (rst),
    .if_valid (if_valid), .if_pc (if_pc),
    .id_valid (id_valid), .id_pc (id_pc), .id_instruction (id_instruction),
    .id_illegal_inst (id_illegal_inst), .id_ecall (id_ecall), .id_ebreak (id_ebreak),
    .mem_valid (mem_valid), .mem_pc (mem_pc), .mem_instruction (mem_instruction),
    .mem_addr (mem_addr), .mem_read (mem_read), .mem_write (mem_write),
    .mem_funct3 (mem_funct3), .mem_page_fault (mem_page_fault),
    .mem_fault_vaddr (mem_fault_vaddr), .mret (mret),
    .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
    .pwdata (pwdata), .pready (pready), .prdata (prdata), .pslverr (pslverr),
    .trap (trap), .trap_cause (trap_cause), .trap_val (trap_val),
    .trap_target (trap_target), .ret_pc (ret_pc), .priv (priv)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout, run did not finish within %0d cycles", cycle_limit);
      $display("test failed");
      $finish;
    end
  end

  // ==================================================
  // Helpers
  // ==================================================

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Stage number that raises each cause
  function automatic int stage_of_cause(input cause_t cause);
    case (cause)
      CAUSE_INST_MISALIGNED: return 0;
      CAUSE_ILLEGAL_INST, CAUSE_BREAKPOINT: return 1;
      CAUSE_ECALL_U, CAUSE_ECALL_S, CAUSE_ECALL_M: return 1;
      default: return 2;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    check_count++;
    assert (act === exp) else begin
      error_count++;
      $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic clear_stage_inputs();
    {if_valid, id_valid, id_illegal_inst, id_ecall, id_ebreak} = '0;
    {mem_valid, mem_read, mem_write, mem_page_fault} = '0;
    {if_pc, id_pc, mem_pc, mem_addr, mem_fault_vaddr} = '0;
    id_instruction = '0;
    mem_instruction = '0;
    mem_funct3 = F3_B;
  endtask

  // Called 1 ns after a rising edge and returns at the same point
  task automatic apb_transfer(input logic write, input csr_addr_t addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    int access_cycles;
    access_cycles = 0;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = wdata;
    @(posedge clk);
    #1 penable = 1'b1;
    // Sample at the falling edge where outputs are settled
    do begin
      @(negedge clk);
      access_cycles++;
    end while (!pready);
    check_value("pready_access_cycle", 32'd2, access_cycles);
    rdata = prdata;
    err = pslverr;
    @(posedge clk);
    #1 psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  // Bus write of mpp and then mret moves it into priv
  task automatic set_privilege(input priv_t mode);
    logic [31:0] rdata;
    logic err;
    apb_transfer(1'b1, OFS_PRIV, {28'd0, mode, 2'b00}, rdata, err);
    check_value("pslverr", 32'd0, err);
    mret = 1'b1;
    @(posedge clk);
    #1 mret = 1'b0;
    check_value("priv", mode, priv);
  endtask

  // Expected outcome of a random row from the alignment rules
  task automatic predict_alignment(input row_t r, input logic [31:0] pc,
                                   input logic [31:0] addr, output logic trap_exp,
                                   output cause_t cause_exp, output logic [31:0] val_exp);
    int unsigned size;
    size = 1 << r.funct3[1:0];
    trap_exp = 1'b0;
    cause_exp = '0;
    val_exp = '0;
    if (r.flags[8]) begin
      // Without compressed instructions fetch needs 4-byte alignment
      if (pc % 4 != 0) begin
        trap_exp = 1'b1;
        cause_exp = CAUSE_INST_MISALIGNED;
        val_exp = pc;
      end
    end else if (addr % size != 0) begin
      trap_exp = 1'b1;
      cause_exp = r.flags[1] ? CAUSE_STORE_MISALIGNED : CAUSE_LOAD_MISALIGNED;
      val_exp = addr;
    end
  endtask

  // Only the stage of the expected cause carries the row pc
  // so mepc shows which stage the trap was taken from
  task automatic drive_row(input row_t r, input logic [31:0] pc, input logic [31:0] addr,
                           input int stage);
    {if_valid, id_valid, id_ebreak, id_ecall, id_illegal_inst} = r.flags[8:4];
    {mem_valid, mem_read, mem_write, mem_page_fault} = r.flags[3:0];
    if_pc = (stage == 0) ? pc : pc + 32'h100;
    id_pc = (stage == 1) ? pc : pc + 32'h200;
    mem_pc = (stage == 2) ? pc : pc + 32'h300;
    id_instruction = r.inst;
    mem_instruction = r.inst;
    mem_addr = addr;
    mem_fault_vaddr = addr + 32'h1000;
    mem_funct3 = r.funct3;
  endtask

  task automatic check_trap_regs();
    logic [31:0] rdata;
    logic err;
    apb_transfer(1'b0, OFS_MEPC, '0, rdata, err);
    check_value("mepc", exp_mepc, rdata);
    apb_transfer(1'b0, OFS_MCAUSE, '0, rdata, err);
    check_value("mcause", exp_mcause, rdata);
    apb_transfer(1'b0, OFS_MTVAL, '0, rdata, err);
    check_value("mtval", exp_mtval, rdata);
    check_value("ret_pc", exp_mepc, ret_pc);
  endtask

  // ==================================================
  // Main sequence
  // ==================================================

  initial begin
    row_t r;
    logic [31:0] pc;
    logic [31:0] addr;
    logic trap_exp;
    cause_t cause_exp;
    logic [31:0] val_exp;
    logic [31:0] rdata;
    logic err;
    rst = 1'b1;
    mret = 1'b0;
    {psel, penable, pwrite} = '0;
    paddr = '0;
    pwdata = '0;
    clear_stage_inputs();
    load_rows();
    repeat (16) @(posedge clk);
    #1 rst = 1'b0;
    check_value("priv", PRIV_M, priv);
    check_value("pready", 32'd0, pready);
    check_value("trap", 32'd0, trap);
    // Trap registers come out of reset cleared with priv M and mpp U
    check_value("trap_target", 32'd0, trap_target);
    check_trap_regs();
    apb_transfer(1'b0, OFS_PRIV, '0, rdata, err);
    check_value("priv_reg", 32'h3, rdata);

    for (int i = 0; i < num_rows; i++) begin
      r = rows[i];
      pc = r.pc;
      addr = r.addr;
      trap_exp = r.exp_trap;
      cause_exp = r.exp_cause;
      val_exp = r.exp_val;
      if (r.rnd) begin
        lcg_state = lcg_next(lcg_state);
        pc = r.flags[8] ? lcg_state : {lcg_state[31:2], 2'b00};
        lcg_state = lcg_next(lcg_state);
        addr = lcg_state;
        predict_alignment(r, pc, addr, trap_exp, cause_exp, val_exp);
      end
      set_privilege(r.priv);
      drive_row(r, pc, addr, stage_of_cause(cause_exp));
      @(negedge clk);
      check_value("trap", trap_exp, trap);
      if (trap_exp) begin
        check_value("trap_cause", cause_exp, trap_cause);
        check_value("trap_val", val_exp, trap_val);
        exp_mepc = pc;
        exp_mcause = {27'd0, cause_exp};
        exp_mtval = val_exp;
      end
      @(posedge clk);
      #1 clear_stage_inputs();
      // A trap always lands in M mode
      check_value("priv", trap_exp ? PRIV_M : r.priv, priv);
      check_trap_regs();
    end

    // mtvec drops its low bits and drives trap_target
    apb_transfer(1'b1, OFS_MTVEC, 32'h8000_1237, rdata, err);
    check_value("pslverr", 32'd0, err);
    apb_transfer(1'b0, OFS_MTVEC, '0, rdata, err);
    check_value("mtvec", 32'h8000_1234, rdata);
    check_value("trap_target", 32'h8000_1234, trap_target);
    // mepc keeps 4-byte alignment with c_ext off
    apb_transfer(1'b1, OFS_MEPC, 32'h0000_7007, rdata, err);
    check_value("pslverr", 32'd0, err);
    exp_mepc = 32'h0000_7004;
    // Read-only and unmapped offsets
    apb_transfer(1'b1, OFS_MCAUSE, 32'h0000_001f, rdata, err);
    check_value("pslverr", 32'd1, err);
    apb_transfer(1'b1, OFS_MTVAL, 32'hffff_ffff, rdata, err);
    check_value("pslverr", 32'd1, err);
    apb_transfer(1'b0, 5'h14, '0, rdata, err);
    check_value("pslverr", 32'd1, err);
    apb_transfer(1'b1, 5'h14, 32'hffff_ffff, rdata, err);
    check_value("pslverr", 32'd1, err);
    check_trap_regs();
    apb_transfer(1'b0, OFS_MTVEC, '0, rdata, err);
    check_value("mtvec", 32'h8000_1234, rdata);
    check_value("pslverr", 32'd0, err);

    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+.
trap_pkg.sv
exception_unit.sv
trap_csr_file.sv
csr_apb_slave.sv
trap_subsystem.sv
tb_trap_subsystem.sv

//--- Bender.yml
package:
  name: trap_subsystem

sources:
  - files:
      - trap_pkg.sv
      - exception_unit.sv
      - trap_csr_file.sv
      - csr_apb_slave.sv
      - trap_subsystem.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_trap_subsystem.sv
